// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := switch_wrapper_tb
FILELIST   := switch_wrapper.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== src/noc_pkg.sv ====
package noc_pkg;

    localparam int NUM_NODES   = 4;
    localparam int NUM_VCS_MAX = 2;

    typedef enum logic [1:0] {
        FLIT_HEAD   = 2'd0,
        FLIT_BODY   = 2'd1,
        FLIT_TAIL   = 2'd2,
        FLIT_SINGLE = 2'd3     // One-flit packet
    } flit_kind_e;

    typedef struct packed {
        logic [1:0] dest;
        logic [1:0] src;
        logic [9:0] seq;       // Sender tag
    } flit_head_t;

    typedef struct packed {
        logic [13:0] data;
    } flit_body_t;

    // Head and single flits carry the route, the others carry data
    typedef union packed {
        flit_head_t head;
        flit_body_t body;
    } flit_payload_u;

    typedef struct packed {
        flit_kind_e                     kind;
        logic [$clog2(NUM_VCS_MAX)-1:0] vc;
        flit_payload_u                  payload;
    } flit_t;

    typedef struct packed {
        flit_t flit;
        logic  valid;          // One-cycle strobe
    } link_t;

    typedef logic [NUM_VCS_MAX-1:0] credit_t;   // One pulse bit per VC

    // Fixed routes, port 0 is always the local endpoint
    function automatic logic [1:0] next_port(input logic [1:0] node, input logic [1:0] dest);
        logic [1:0] port;
        if (dest == node) begin
            port = 2'd0;
        end else if (node == 2'd3 && dest == 2'd1) begin
            port = 2'd2;
        end else begin
            port = 2'd1;       // Ring direction, node 3 reaches node 2 through node 0
        end
        return port;
    endfunction

endpackage

// ==== src/switch.sv ====
`timescale 1ns/1ps

module switch #(
    parameter int NUM_OUTPORTS = 2,
    parameter int NUM_BUFFERS  = 2,
    parameter int NUM_VCS      = 2,
    parameter int BUFFER_SIZE  = 8,
    parameter int NODE_ID      = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::link_t     in_link [NUM_BUFFERS],        // Inport 0 is local
    input  noc_pkg::credit_t   credit_in [1:NUM_OUTPORTS-1],
    input  logic               packet_sent,
    output noc_pkg::link_t     out_link [1:NUM_OUTPORTS-1],
    output noc_pkg::flit_t     out_local,
    output logic               local_ready,
    output noc_pkg::credit_t   credit_out [1:NUM_BUFFERS-1],
    output logic [NUM_VCS-1:0] buffer_available
);
    noc_pkg::flit_t          front [NUM_BUFFERS][NUM_VCS];
    logic [NUM_VCS-1:0]      front_valid [NUM_BUFFERS];
    noc_pkg::credit_t        pop [NUM_BUFFERS];
    noc_pkg::credit_t        alloc_credit [NUM_OUTPORTS];
    noc_pkg::flit_t          grant_flit [NUM_OUTPORTS];
    logic [NUM_OUTPORTS-1:0] grant_valid;
    logic                    local_ack;
    logic                    local_busy;

    for (genvar b = 0; b < NUM_BUFFERS; b++) begin : g_in
        logic [NUM_VCS-1:0] not_full;
        noc_pkg::credit_t   credit;

        vc_buffer #(
            .NUM_VCS(NUM_VCS),
            .BUFFER_SIZE(BUFFER_SIZE)
        ) u_buf (
            .clk(clk), .rst_n(rst_n),
            .push(in_link[b]), .pop(pop[b]),
            .front(front[b]), .front_valid(front_valid[b]),
            .not_full(not_full), .credit(credit)
        );

        if (b == 0) begin : g_local
            assign buffer_available = not_full;
        end else begin : g_net
            assign credit_out[b] = credit;
        end
    end

    assign local_ack  = local_ready && packet_sent;
    assign local_busy = local_ready && !packet_sent;

    // Local acknowledge acts as the credit return of outport 0
    assign alloc_credit[0] = local_ack ? (noc_pkg::credit_t'(1) << out_local.vc) : '0;

    for (genvar k = 1; k < NUM_OUTPORTS; k++) begin : g_out
        noc_pkg::flit_t flit_q;
        logic           valid_q;

        assign alloc_credit[k] = credit_in[k];

        always_ff @(posedge clk) begin
            flit_q <= grant_flit[k];
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= grant_valid[k];
            end
        end

        assign out_link[k] = '{flit: flit_q, valid: valid_q};
    end

    switch_allocator #(
        .NUM_OUTPORTS(NUM_OUTPORTS), .NUM_BUFFERS(NUM_BUFFERS), .NUM_VCS(NUM_VCS),
        .BUFFER_SIZE(BUFFER_SIZE), .NODE_ID(NODE_ID)
    ) u_alloc (
        .clk(clk), .rst_n(rst_n),
        .front(front), .front_valid(front_valid),
        .credit_in(alloc_credit), .local_busy(local_busy),
        .pop(pop), .grant_flit(grant_flit), .grant_valid(grant_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Local output, held until the endpoint takes it

    always_ff @(posedge clk) begin
        if (grant_valid[0]) begin
            out_local <= grant_flit[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            local_ready <= 1'b0;
        end else if (grant_valid[0]) begin
            local_ready <= 1'b1;
        end else if (packet_sent) begin
            local_ready <= 1'b0;
        end
    end

    a_local_hold: assert property (@(posedge clk) disable iff (!rst_n)
        local_busy |=> local_ready && $stable(out_local))
        else $error("switch %0d: local output changed before packet_sent", NODE_ID);

endmodule

// ==== src/switch_allocator.sv ====
`timescale 1ns/1ps

module switch_allocator #(
    parameter int NUM_OUTPORTS = 2,
    parameter int NUM_BUFFERS  = 2,
    parameter int NUM_VCS      = 2,
    parameter int BUFFER_SIZE  = 8,
    parameter int NODE_ID      = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  noc_pkg::flit_t          front [NUM_BUFFERS][NUM_VCS],
    input  logic [NUM_VCS-1:0]      front_valid [NUM_BUFFERS],
    input  noc_pkg::credit_t        credit_in [NUM_OUTPORTS],
    input  logic                    local_busy,
    output noc_pkg::credit_t        pop [NUM_BUFFERS],
    output noc_pkg::flit_t          grant_flit [NUM_OUTPORTS],
    output logic [NUM_OUTPORTS-1:0] grant_valid
);
    localparam int NUM_REQ = NUM_BUFFERS * NUM_VCS;
    localparam int REQ_W   = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;
    localparam int CNT_W   = $clog2(BUFFER_SIZE + 1);

    // Requester r is VC (r % NUM_VCS) of inport (r / NUM_VCS)
    noc_pkg::flit_t     req_flit [NUM_REQ];
    logic [NUM_REQ-1:0] req_valid;
    logic [NUM_REQ-1:0] req_head;
    logic [1:0]         req_port [NUM_REQ];
    logic [1:0]         route_q [NUM_REQ];    // Outport of the packet in flight

    logic [NUM_REQ-1:0] elig [NUM_OUTPORTS];
    logic [REQ_W-1:0]   gnt_idx [NUM_OUTPORTS];
    logic [REQ_W-1:0]   rr_ptr [NUM_OUTPORTS];
    logic [NUM_VCS-1:0] lock_valid [NUM_OUTPORTS];
    logic [REQ_W-1:0]   lock_owner [NUM_OUTPORTS][NUM_VCS];
    logic [CNT_W-1:0]   credit_cnt [NUM_OUTPORTS][NUM_VCS];

    ////////////////////////////////////////////////////////////////////////////
    // Route and eligibility

    always_comb begin
        for (int r = 0; r < NUM_REQ; r++) begin
            req_flit[r]  = front[r / NUM_VCS][r % NUM_VCS];
            req_valid[r] = front_valid[r / NUM_VCS][r % NUM_VCS];
            req_head[r]  = (req_flit[r].kind == noc_pkg::FLIT_HEAD) ||
                           (req_flit[r].kind == noc_pkg::FLIT_SINGLE);
            req_port[r]  = req_head[r] ?
                           noc_pkg::next_port(2'(NODE_ID), req_flit[r].payload.head.dest) :
                           route_q[r];
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_OUTPORTS; k++) begin
            for (int r = 0; r < NUM_REQ; r++) begin
                elig[k][r] = req_valid[r] && (int'(req_port[r]) == k) &&
                             (lock_valid[k][r % NUM_VCS] ?
                                 (int'(lock_owner[k][r % NUM_VCS]) == r) : req_head[r]) &&
                             (credit_cnt[k][r % NUM_VCS] != '0) &&
                             (k != 0 || !local_busy);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin grant, one flit per outport

    always_comb begin
        int idx;
        for (int k = 0; k < NUM_OUTPORTS; k++) begin
            grant_valid[k] = 1'b0;
            gnt_idx[k]     = '0;
            for (int i = 0; i < NUM_REQ; i++) begin
                idx = (int'(rr_ptr[k]) + i) % NUM_REQ;
                if (!grant_valid[k] && elig[k][idx]) begin
                    grant_valid[k] = 1'b1;
                    gnt_idx[k]     = REQ_W'(idx);
                end
            end
            grant_flit[k] = req_flit[gnt_idx[k]];
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            pop[b] = '0;
        end
        for (int k = 0; k < NUM_OUTPORTS; k++) begin
            if (grant_valid[k]) begin
                pop[int'(gnt_idx[k]) / NUM_VCS][int'(gnt_idx[k]) % NUM_VCS] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Locks, pointers and credit counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_OUTPORTS; k++) begin
                rr_ptr[k]     <= '0;
                lock_valid[k] <= '0;
                for (int v = 0; v < NUM_VCS; v++) begin
                    lock_owner[k][v] <= '0;
                    credit_cnt[k][v] <= CNT_W'(BUFFER_SIZE);
                end
            end
            for (int r = 0; r < NUM_REQ; r++) begin
                route_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_OUTPORTS; k++) begin
                if (grant_valid[k]) begin
                    rr_ptr[k] <= (int'(gnt_idx[k]) == NUM_REQ - 1) ? '0 : gnt_idx[k] + 1'b1;
                    if (grant_flit[k].kind == noc_pkg::FLIT_HEAD) begin
                        lock_valid[k][grant_flit[k].vc] <= 1'b1;
                        lock_owner[k][grant_flit[k].vc] <= gnt_idx[k];
                        route_q[gnt_idx[k]]             <= 2'(k);
                    end else if (grant_flit[k].kind == noc_pkg::FLIT_TAIL) begin
                        lock_valid[k][grant_flit[k].vc] <= 1'b0;   // Path released
                    end
                end
                for (int v = 0; v < NUM_VCS; v++) begin
                    credit_cnt[k][v] <= credit_cnt[k][v] + CNT_W'(credit_in[k][v]) -
                        CNT_W'(grant_valid[k] && (int'(grant_flit[k].vc) == v));
                end
            end
        end
    end

    for (genvar k = 0; k < NUM_OUTPORTS; k++) begin : g_chk
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            logic vc_gnt;

            assign vc_gnt = grant_valid[k] && (int'(grant_flit[k].vc) == v);

            // Downstream never returns more credits than it has slots
            a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
                credit_cnt[k][v] <= CNT_W'(BUFFER_SIZE))
                else $error("allocator: credit count above buffer size, port %0d", k);

            // A locked path only carries the rest of its packet
            a_lock_hold: assert property (@(posedge clk) disable iff (!rst_n)
                lock_valid[k][v] && vc_gnt |->
                    (grant_flit[k].kind == noc_pkg::FLIT_BODY) ||
                    (grant_flit[k].kind == noc_pkg::FLIT_TAIL))
                else $error("allocator: new packet on a locked path, port %0d", k);
        end
    end

endmodule

// ==== src/switch_wrapper.sv ====
`timescale 1ns/1ps

module switch_wrapper #(
    parameter int BUFFER_SIZE = 8,
    parameter int NUM_VCS     = 2
) (
    input  logic           clk,
    input  logic           rst_n,
    input  noc_pkg::flit_t in_flit          [noc_pkg::NUM_NODES-1:0],
    input  logic           data_ready_in    [noc_pkg::NUM_NODES-1:0],
    input  logic           packet_sent      [noc_pkg::NUM_NODES-1:0],
    output noc_pkg::flit_t out              [noc_pkg::NUM_NODES-1:0],
    output logic           data_ready_out   [noc_pkg::NUM_NODES-1:0],
    output logic           buffer_available [2*noc_pkg::NUM_NODES-1:0],
    output logic           credit_granted   [noc_pkg::NUM_NODES-1:0]
);
    noc_pkg::link_t     n0_in [2];
    noc_pkg::link_t     n1_in [2];
    noc_pkg::link_t     n2_in [3];
    noc_pkg::link_t     n3_in [2];
    noc_pkg::link_t     n0_out [1:1];
    noc_pkg::link_t     n1_out [1:1];
    noc_pkg::link_t     n2_out [1:1];
    noc_pkg::link_t     n3_out [1:2];
    noc_pkg::credit_t   n0_cin [1:1];
    noc_pkg::credit_t   n1_cin [1:1];
    noc_pkg::credit_t   n2_cin [1:1];
    noc_pkg::credit_t   n3_cin [1:2];
    noc_pkg::credit_t   n0_cout [1:1];
    noc_pkg::credit_t   n1_cout [1:1];
    noc_pkg::credit_t   n2_cout [1:2];
    noc_pkg::credit_t   n3_cout [1:1];
    logic [NUM_VCS-1:0] avail [noc_pkg::NUM_NODES];

    ////////////////////////////////////////////////////////////////////////////
    // Links between nodes

    assign n0_in[0]  = '{flit: in_flit[0], valid: data_ready_in[0]};
    assign n0_in[1]  = n3_out[1];
    assign n0_cin[1] = n2_cout[1];

    assign n1_in[0]  = '{flit: in_flit[1], valid: data_ready_in[1]};
    assign n1_in[1]  = n3_out[2];
    assign n1_cin[1] = n2_cout[2];

    assign n2_in[0]  = '{flit: in_flit[2], valid: data_ready_in[2]};
    assign n2_in[1]  = n0_out[1];
    assign n2_in[2]  = n1_out[1];
    assign n2_cin[1] = n3_cout[1];

    assign n3_in[0]  = '{flit: in_flit[3], valid: data_ready_in[3]};
    assign n3_in[1]  = n2_out[1];
    assign n3_cin[1] = n0_cout[1];   // Outport 1 of node 3 feeds node 0
    assign n3_cin[2] = n1_cout[1];

    ////////////////////////////////////////////////////////////////////////////
    // Switches

    switch #(
        .NUM_OUTPORTS(2), .NUM_BUFFERS(2), .NUM_VCS(NUM_VCS),
        .BUFFER_SIZE(BUFFER_SIZE), .NODE_ID(0)
    ) switch0 (
        .clk(clk), .rst_n(rst_n),
        .in_link(n0_in), .credit_in(n0_cin), .packet_sent(packet_sent[0]),
        .out_link(n0_out), .out_local(out[0]), .local_ready(data_ready_out[0]),
        .credit_out(n0_cout), .buffer_available(avail[0])
    );

    switch #(
        .NUM_OUTPORTS(2), .NUM_BUFFERS(2), .NUM_VCS(NUM_VCS),
        .BUFFER_SIZE(BUFFER_SIZE), .NODE_ID(1)
    ) switch1 (
        .clk(clk), .rst_n(rst_n),
        .in_link(n1_in), .credit_in(n1_cin), .packet_sent(packet_sent[1]),
        .out_link(n1_out), .out_local(out[1]), .local_ready(data_ready_out[1]),
        .credit_out(n1_cout), .buffer_available(avail[1])
    );

    switch #(
        .NUM_OUTPORTS(2), .NUM_BUFFERS(3), .NUM_VCS(NUM_VCS),
        .BUFFER_SIZE(BUFFER_SIZE), .NODE_ID(2)
    ) switch2 (
        .clk(clk), .rst_n(rst_n),
        .in_link(n2_in), .credit_in(n2_cin), .packet_sent(packet_sent[2]),
        .out_link(n2_out), .out_local(out[2]), .local_ready(data_ready_out[2]),
        .credit_out(n2_cout), .buffer_available(avail[2])
    );

    switch #(
        .NUM_OUTPORTS(3), .NUM_BUFFERS(2), .NUM_VCS(NUM_VCS),
        .BUFFER_SIZE(BUFFER_SIZE), .NODE_ID(3)
    ) switch3 (
        .clk(clk), .rst_n(rst_n),
        .in_link(n3_in), .credit_in(n3_cin), .packet_sent(packet_sent[3]),
        .out_link(n3_out), .out_local(out[3]), .local_ready(data_ready_out[3]),
        .credit_out(n3_cout), .buffer_available(avail[3])
    );

    for (genvar n = 0; n < noc_pkg::NUM_NODES; n++) begin : g_ep
        assign buffer_available[n]                     = avail[n][0];
        assign buffer_available[n + noc_pkg::NUM_NODES] = avail[n][1];   // VC1 in upper half
        assign credit_granted[n] = data_ready_out[n] && packet_sent[n];
    end

endmodule

// ==== src/vc_buffer.sv ====
`timescale 1ns/1ps

module vc_buffer #(
    parameter int NUM_VCS     = 2,
    parameter int BUFFER_SIZE = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::link_t     push,
    input  noc_pkg::credit_t   pop,
    output noc_pkg::flit_t     front [NUM_VCS],
    output logic [NUM_VCS-1:0] front_valid,
    output logic [NUM_VCS-1:0] not_full,
    output noc_pkg::credit_t   credit
);
    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
        noc_pkg::flit_t   mem [BUFFER_SIZE];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             wr_en;
        logic             rd_en;

        assign wr_en = push.valid && (int'(push.flit.vc) == v);   // Steer by the flit's VC
        assign rd_en = pop[v];

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_ptr] <= push.flit;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (rd_en) begin
                    rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
                end
                count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
            end
        end

        assign front[v]       = mem[rd_ptr];
        assign front_valid[v] = (count != '0);
        assign not_full[v]    = (count != CNT_W'(BUFFER_SIZE));

        // Sender must honour credits or buffer_available
        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            wr_en |-> not_full[v])
            else $error("vc_buffer: push into full VC %0d", v);

        // Allocator only pops a VC that shows a front flit
        a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
            rd_en |-> front_valid[v])
            else $error("vc_buffer: pop from empty VC %0d", v);
    end

    // Credit goes back one cycle after the pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit <= '0;
        end else begin
            credit <= pop;
        end
    end

endmodule

// ==== switch_wrapper.f ====
src/noc_pkg.sv
src/vc_buffer.sv
src/switch_allocator.sv
src/switch.sv
src/switch_wrapper.sv
verification/switch_wrapper_tb.sv

// ==== verification/switch_wrapper_tb.sv ====
`timescale 1ns/1ps

module switch_wrapper_tb;

    localparam int N            = noc_pkg::NUM_NODES;
    localparam int STALL_NODE   = 2;
    localparam int STALL_CYCLES = 300;
    localparam int DRAIN_LIMIT  = 2000;

    logic           clk;
    logic           rst_n;
    noc_pkg::flit_t in_flit          [N-1:0];
    logic           data_ready_in    [N-1:0];
    logic           packet_sent      [N-1:0];
    noc_pkg::flit_t out              [N-1:0];
    logic           data_ready_out   [N-1:0];
    logic           buffer_available [2*N-1:0];
    logic           credit_granted   [N-1:0];

    noc_pkg::flit_t exp_q [N*N*2][$];    // Index src*8 + dest*2 + vc

    int         err_data;
    int         err_proto;
    int         err_timeout;
    int         pkt_len [N];
    int         pkt_pos [N];
    logic [1:0] pkt_dest [N];
    logic       pkt_vc [N];
    logic [9:0] seq_cnt [N];
    logic       rx_open [N][2];          // A head arrived, tail still due
    logic [1:0] rx_src [N][2];
    bit         stall;

    switch_wrapper #(.BUFFER_SIZE(8), .NUM_VCS(2)) switch_wrapper_inst (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit), .data_ready_in(data_ready_in), .packet_sent(packet_sent),
        .out(out), .data_ready_out(data_ready_out),
        .buffer_available(buffer_available), .credit_granted(credit_granted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Endpoint handshake checks

    for (genvar n = 0; n < N; n++) begin : g_chk
        a_credit: assert property (@(posedge clk) disable iff (!rst_n)
            credit_granted[n] == (data_ready_out[n] && packet_sent[n]))
            else begin
                err_proto++;
                $display("FAIL %0t credit_granted[%0d] got %b expected %b", $time, n,
                         $sampled(credit_granted[n]),
                         $sampled(data_ready_out[n] && packet_sent[n]));
            end

        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_out[n] && !packet_sent[n] |=> data_ready_out[n] && $stable(out[n]))
            else begin
                err_proto++;
                $display("Node %0d changed its output before packet_sent at %0t", n, $time);
            end

        a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
            data_ready_in[n] |-> buffer_available[n + N*int'(in_flit[n].vc)])
            else begin
                err_proto++;
                $display("Node %0d strobed a flit into a full buffer at %0t", n, $time);
            end
    end

    function automatic noc_pkg::flit_t make_flit(input int n);
        noc_pkg::flit_t f;
        f.vc = pkt_vc[n];
        if (pkt_len[n] == 1) begin
            f.kind = noc_pkg::FLIT_SINGLE;
        end else if (pkt_pos[n] == 0) begin
            f.kind = noc_pkg::FLIT_HEAD;
        end else if (pkt_pos[n] == pkt_len[n] - 1) begin
            f.kind = noc_pkg::FLIT_TAIL;
        end else begin
            f.kind = noc_pkg::FLIT_BODY;
        end
        if (f.kind == noc_pkg::FLIT_HEAD || f.kind == noc_pkg::FLIT_SINGLE) begin
            f.payload.head.dest = pkt_dest[n];
            f.payload.head.src  = 2'(n);
            f.payload.head.seq  = seq_cnt[n];
        end else begin
            f.payload.body.data = 14'($urandom);
        end
        return f;
    endfunction

    // Node 3 never targets node 2, so no packet path closes the 0-2-3 ring
    task automatic send_step(input bit allow_new);
        noc_pkg::flit_t f;
        for (int n = 0; n < N; n++) begin
            data_ready_in[n] = 1'b0;
            if (pkt_pos[n] == pkt_len[n] && allow_new && ($urandom % 3 == 0)) begin
                pkt_len[n]  = 1 + int'($urandom % 4);
                pkt_pos[n]  = 0;
                pkt_dest[n] = 2'($urandom % N);
                if (n == 3 && pkt_dest[n] == 2'd2) begin
                    pkt_dest[n] = 2'd1;
                end
                pkt_vc[n]  = 1'($urandom % 2);
                seq_cnt[n] = seq_cnt[n] + 1'b1;
            end
            if (pkt_pos[n] < pkt_len[n] && buffer_available[n + N*int'(pkt_vc[n])]) begin
                f = make_flit(n);
                exp_q[n*N*2 + int'(pkt_dest[n])*2 + int'(pkt_vc[n])].push_back(f);
                in_flit[n]       = f;
                data_ready_in[n] = 1'b1;
                pkt_pos[n]++;
            end
        end
    endtask

    task automatic recv_step();
        noc_pkg::flit_t f;
        noc_pkg::flit_t e;
        logic [1:0]     src;
        int             key;
        for (int d = 0; d < N; d++) begin
            packet_sent[d] = !(stall && d == STALL_NODE) && ($urandom % 4 != 0);
            if (data_ready_out[d] && packet_sent[d]) begin
                f = out[d];
                if (f.kind == noc_pkg::FLIT_HEAD || f.kind == noc_pkg::FLIT_SINGLE) begin
                    assert (!rx_open[d][f.vc]) else begin
                        err_proto++;
                        $display("Node %0d got a new packet inside an open one on VC %0d",
                                 d, f.vc);
                    end
                    assert (f.payload.head.dest == 2'(d)) else begin
                        err_data++;
                        $display("FAIL %0t out[%0d].dest got %0d expected %0d", $time, d,
                                 f.payload.head.dest, d);
                    end
                    src             = f.payload.head.src;
                    rx_src[d][f.vc] = src;
                    rx_open[d][f.vc] = (f.kind == noc_pkg::FLIT_HEAD);
                end else begin
                    assert (rx_open[d][f.vc]) else begin
                        err_proto++;
                        $display("Node %0d got a body or tail flit with no head on VC %0d",
                                 d, f.vc);
                    end
                    src = rx_src[d][f.vc];
                    if (f.kind == noc_pkg::FLIT_TAIL) begin
                        rx_open[d][f.vc] = 1'b0;
                    end
                end
                key = int'(src)*N*2 + d*2 + int'(f.vc);
                if (exp_q[key].size() == 0) begin
                    err_data++;
                    $display("Node %0d received a flit that was never sent at %0t", d, $time);
                end else begin
                    e = exp_q[key].pop_front();
                    assert (f == e) else begin
                        err_data++;
                        $display("FAIL %0t out[%0d] got %h expected %h", $time, d, f, e);
                    end
                end
            end
        end
    endtask

    function automatic int pending();
        int total;
        total = 0;
        for (int k = 0; k < N*N*2; k++) begin
            total += exp_q[k].size();
        end
        return total;
    endfunction

    function automatic bit senders_idle();
        bit idle;
        idle = 1'b1;
        for (int n = 0; n < N; n++) begin
            idle &= (pkt_pos[n] == pkt_len[n]);
        end
        return idle;
    endfunction

    task automatic run_traffic(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            recv_step();
            send_step(1'b1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int cycles;
        void'($urandom(32'h5648));
        rst_n = 1'b0;
        stall = 1'b0;
        err_data = 0;
        err_proto = 0;
        err_timeout = 0;
        for (int n = 0; n < N; n++) begin
            in_flit[n]       = '0;
            data_ready_in[n] = 1'b0;
            packet_sent[n]   = 1'b0;
            pkt_len[n]       = 0;
            pkt_pos[n]       = 0;
            pkt_dest[n]      = '0;
            pkt_vc[n]        = 1'b0;
            seq_cnt[n]       = '0;
            for (int v = 0; v < 2; v++) begin
                rx_open[n][v] = 1'b0;
                rx_src[n][v]  = '0;
            end
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int n = 0; n < N; n++) begin
            assert (!data_ready_out[n]) else begin
                err_proto++;
                $display("FAIL %0t data_ready_out[%0d] got 1 expected 0", $time, n);
            end
            assert (!credit_granted[n]) else begin
                err_proto++;
                $display("FAIL %0t credit_granted[%0d] got 1 expected 0", $time, n);
            end
        end
        for (int i = 0; i < 2*N; i++) begin
            assert (buffer_available[i]) else begin
                err_proto++;
                $display("FAIL %0t buffer_available[%0d] got 0 expected 1", $time, i);
            end
        end

        run_traffic(1000);
        stall = 1'b1;                    // Back-pressure at one endpoint
        run_traffic(STALL_CYCLES);
        stall = 1'b0;
        run_traffic(500);

        cycles = 0;
        while (!senders_idle() && cycles < 500) begin
            @(negedge clk);
            recv_step();
            send_step(1'b0);
            cycles++;
        end
        if (!senders_idle()) begin
            err_timeout++;
            $display("Timeout: endpoints could not finish their last packets");
        end

        cycles = 0;
        while (pending() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            recv_step();
            send_step(1'b0);
            cycles++;
        end
        if (pending() != 0) begin
            err_timeout++;
            $display("Timeout: %0d flits were never delivered", pending());
        end

        $display("Errors: data %0d, protocol %0d, timeout %0d", err_data, err_proto, err_timeout);
        if (err_data + err_proto + err_timeout == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
